//--- logic/mmu_pkg.sv
// array sizes, element types, AXI4-Lite structs, register map and sequencing constants
package mmu_pkg;

    ////////////////////
    // array geometry
    ////////////////////
    localparam int ARRAY_DIM = 4;
    localparam int DATA_W    = 8;
    localparam int ACC_W     = 32;

    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // one matrix row, byte c is column c
    typedef data_t [ARRAY_DIM-1:0] data_vec_t;
    typedef acc_t  [ARRAY_DIM-1:0] acc_vec_t;

    ////////////////////
    // host bus
    ////////////////////
    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;

    typedef struct packed {
        logic                     awvalid;
        logic [AXIL_ADDR_W-1:0]   awaddr;
        logic                     wvalid;
        logic [AXIL_DATA_W-1:0]   wdata;
        logic [AXIL_DATA_W/8-1:0] wstrb;
        logic                     bready;
        logic                     arvalid;
        logic [AXIL_ADDR_W-1:0]   araddr;
        logic                     rready;
    } axil_req_t;

    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
    } axil_rsp_t;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // register map, byte addresses
    localparam logic [AXIL_ADDR_W-1:0] ADDR_W_BASE = 8'h00;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_A_BASE = 8'h10;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_CTRL   = 8'h20;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_STATUS = 8'h24;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_C_BASE = 8'h40;

    // last input row issued until last result row presented to the registers
    localparam int DRAIN_CYCLES = 2 * ARRAY_DIM + 1;

    // delay of one skew lane, mirrored for the deskew side
    function automatic int skew_depth(int lane, bit reverse);
        return reverse ? ARRAY_DIM - 1 - lane : lane;
    endfunction

endpackage

//--- logic/mac.sv
// weight-stationary multiply-accumulate cell
`timescale 1ns/1ps

module mac (
    input  logic           clk,
    input  logic           reset,
    input  logic           load_weight,
    input  mmu_pkg::data_t weight_in,
    input  mmu_pkg::data_t data_in,
    input  mmu_pkg::acc_t  psum_in,
    output mmu_pkg::data_t weight_out,
    output mmu_pkg::data_t data_out,
    output mmu_pkg::acc_t  psum_out
);

    mmu_pkg::data_t weight_q;

    // stored weight doubles as the east link of the load chain
    assign weight_out = weight_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            weight_q <= '0;
            data_out <= '0;
            psum_out <= '0;
        end else if (load_weight) begin
            // operand and sum links hold while weights shift
            weight_q <= weight_in;
        end else begin
            data_out <= data_in;
            // all operands signed, product sign-extends into the sum
            psum_out <= psum_in + data_in * weight_q;
        end
    end

endmodule

//--- logic/systolic_array.sv
// square grid of mac cells with west weight loading, south operands and east sums
`timescale 1ns/1ps

module systolic_array (
    input  logic               clk,
    input  logic               reset,
    input  logic               load_weight,
    input  mmu_pkg::data_vec_t weight_feed,
    input  mmu_pkg::data_vec_t data_feed,
    output mmu_pkg::acc_vec_t  psum_east
);

    // [row][col] links, the extra index is the south or east edge
    mmu_pkg::data_t data_s   [mmu_pkg::ARRAY_DIM+1][mmu_pkg::ARRAY_DIM];
    mmu_pkg::data_t weight_e [mmu_pkg::ARRAY_DIM][mmu_pkg::ARRAY_DIM+1];
    mmu_pkg::acc_t  psum_e   [mmu_pkg::ARRAY_DIM][mmu_pkg::ARRAY_DIM+1];

    ////////////////////
    // array edges
    ////////////////////
    for (genvar c = 0; c < mmu_pkg::ARRAY_DIM; c++) begin : g_north
        assign data_s[0][c] = data_feed[c];
    end

    for (genvar r = 0; r < mmu_pkg::ARRAY_DIM; r++) begin : g_west
        // byte r of the feed loads row r
        assign weight_e[r][0] = weight_feed[r];
        assign psum_e[r][0]   = '0;
        assign psum_east[r]   = psum_e[r][mmu_pkg::ARRAY_DIM];
    end

    ////////////////////
    // cell grid
    ////////////////////
    for (genvar r = 0; r < mmu_pkg::ARRAY_DIM; r++) begin : g_row
        for (genvar c = 0; c < mmu_pkg::ARRAY_DIM; c++) begin : g_col
            mac i_mac (
                .clk        (clk),
                .reset      (reset),
                .load_weight(load_weight),
                .weight_in  (weight_e[r][c]),
                .data_in    (data_s[r][c]),
                .psum_in    (psum_e[r][c]),
                .weight_out (weight_e[r][c+1]),
                .data_out   (data_s[r+1][c]),
                .psum_out   (psum_e[r][c+1])
            );
        end
    end

endmodule

//--- logic/skew_buffer.sv
// per-lane delay line staggering or realigning one row of elements
`timescale 1ns/1ps

module skew_buffer #(
    parameter type elem_t  = mmu_pkg::data_t,
    parameter bit  reverse = 1'b0
) (
    input  logic                             clk,
    input  logic                             reset,
    input  elem_t [mmu_pkg::ARRAY_DIM-1:0]   lanes_in,
    output elem_t [mmu_pkg::ARRAY_DIM-1:0]   lanes_out
);

    for (genvar i = 0; i < mmu_pkg::ARRAY_DIM; i++) begin : g_lane
        if (mmu_pkg::skew_depth(i, reverse) == 0) begin : g_pass
            // zero-depth lane
            assign lanes_out[i] = lanes_in[i];
        end else begin : g_delay
            elem_t stage [mmu_pkg::skew_depth(i, reverse)];

            always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                    stage <= '{default: '0};
                end else begin
                    stage[0] <= lanes_in[i];
                    for (int k = 1; k < $size(stage); k++) begin
                        stage[k] <= stage[k-1];
                    end
                end
            end

            assign lanes_out[i] = stage[$size(stage)-1];
        end
    end

endmodule

//--- logic/mmu_controller.sv
// FSM sequencing weight load, input feed, drain and result writeback
`timescale 1ns/1ps

module mmu_controller (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  mmu_pkg::data_vec_t w_rows [mmu_pkg::ARRAY_DIM],
    input  mmu_pkg::data_vec_t a_rows [mmu_pkg::ARRAY_DIM],
    output logic               load_weight,
    output mmu_pkg::data_vec_t weight_feed,
    output mmu_pkg::data_vec_t data_feed,
    input  mmu_pkg::acc_vec_t  result_row,
    output mmu_pkg::acc_vec_t  result_data,
    output logic               result_we,
    output logic [1:0]         result_idx,
    output logic               busy,
    output logic               done
);

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        FEED,
        DRAIN,
        WRITE
    } state_t;

    state_t     state;
    logic [1:0] cnt;
    logic       last_cnt;

    assign last_cnt = cnt == 2'(mmu_pkg::ARRAY_DIM - 1);

    // last W row first, so the first one pushed ends in the east column
    assign load_weight = state == LOAD;
    assign weight_feed = w_rows[2'(mmu_pkg::ARRAY_DIM - 1) - cnt];

    // held high through the done cycle so status never shows both low mid-run
    assign busy = (state != IDLE) || done;

    ////////////////////
    // state and counter
    ////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            cnt <= cnt + 2'd1;
            case (state)
                IDLE: begin
                    cnt <= '0;
                    if (start) begin
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    if (last_cnt) begin
                        state <= FEED;
                    end
                end
                FEED: begin
                    if (last_cnt) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    // rest of the drain window is the write phase plus done
                    if (cnt == 2'(mmu_pkg::DRAIN_CYCLES - mmu_pkg::ARRAY_DIM - 2)) begin
                        state <= WRITE;
                        cnt   <= '0;
                    end
                end
                WRITE: begin
                    if (last_cnt) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////
    // registered datapath outputs
    ////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            data_feed  <= '0;
            result_we  <= 1'b0;
            result_idx <= '0;
            done       <= 1'b0;
        end else begin
            // zero rows outside the feed phase keep the pipe clean
            data_feed  <= (state == FEED) ? a_rows[cnt] : '0;
            result_we  <= state == WRITE;
            result_idx <= cnt;
            done       <= (state == WRITE) && last_cnt;
        end
    end

    // aligned row i leaves the deskew buffer in write cycle i
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result_data <= '0;
        end else begin
            result_data <= result_row;
        end
    end

endmodule

//--- logic/axil_regs.sv
// AXI4-Lite slave with W, A, control, status and C registers
`timescale 1ns/1ps

module axil_regs (
    input  logic                clk,
    input  logic                reset,
    input  mmu_pkg::axil_req_t  axil_req,
    output mmu_pkg::axil_rsp_t  axil_rsp,
    output mmu_pkg::data_vec_t  w_rows [mmu_pkg::ARRAY_DIM],
    output mmu_pkg::data_vec_t  a_rows [mmu_pkg::ARRAY_DIM],
    output logic                start,
    input  logic                busy,
    input  logic                done,
    input  logic                result_we,
    input  logic [1:0]          result_idx,
    input  mmu_pkg::acc_vec_t   result_row
);

    mmu_pkg::acc_vec_t c_rows [mmu_pkg::ARRAY_DIM];
    logic              done_flag;

    logic                            wr_fire;
    logic                            rd_fire;
    logic [mmu_pkg::AXIL_ADDR_W-1:0] waddr;
    logic [mmu_pkg::AXIL_ADDR_W-1:0] raddr;
    logic                            wr_w;
    logic                            wr_a;
    logic                            wr_ctrl;
    logic [1:0]                      wresp_next;
    logic [mmu_pkg::AXIL_DATA_W-1:0] rdata_next;
    logic [1:0]                      rresp_next;

    // ready is high for one cycle only, and the host holds valid
    assign wr_fire = axil_rsp.awready && axil_req.awvalid && axil_req.wvalid;
    assign rd_fire = axil_rsp.arready && axil_req.arvalid;
    assign waddr   = axil_req.awaddr;
    assign raddr   = axil_req.araddr;

    ////////////////////
    // address decode
    ////////////////////
    assign wr_w    = waddr[7:4] == mmu_pkg::ADDR_W_BASE[7:4];
    assign wr_a    = waddr[7:4] == mmu_pkg::ADDR_A_BASE[7:4];
    assign wr_ctrl = waddr[7:2] == mmu_pkg::ADDR_CTRL[7:2];

    // operands locked during a run, status and C are read only
    assign wresp_next = ((wr_w || wr_a) && !busy) || wr_ctrl ?
                        mmu_pkg::RESP_OKAY : mmu_pkg::RESP_SLVERR;

    always_comb begin
        rdata_next = '0;
        rresp_next = mmu_pkg::RESP_OKAY;
        if (raddr[7:4] == mmu_pkg::ADDR_W_BASE[7:4]) begin
            rdata_next = w_rows[raddr[3:2]];
        end else if (raddr[7:4] == mmu_pkg::ADDR_A_BASE[7:4]) begin
            rdata_next = a_rows[raddr[3:2]];
        end else if (raddr[7:2] == mmu_pkg::ADDR_CTRL[7:2]) begin
            // start clears itself
            rdata_next = '0;
        end else if (raddr[7:2] == mmu_pkg::ADDR_STATUS[7:2]) begin
            rdata_next = {{(mmu_pkg::AXIL_DATA_W-2){1'b0}}, done_flag, busy};
        end else if (raddr[7:6] == mmu_pkg::ADDR_C_BASE[7:6]) begin
            // row in bits 5:4, column in bits 3:2
            rdata_next = c_rows[raddr[5:4]][raddr[3:2]];
        end else begin
            rresp_next = mmu_pkg::RESP_SLVERR;
        end
    end

    ////////////////////
    // handshakes and storage
    ////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            axil_rsp  <= '0;
            w_rows    <= '{default: '0};
            a_rows    <= '{default: '0};
            c_rows    <= '{default: '0};
            start     <= 1'b0;
            done_flag <= 1'b0;
        end else begin
            // write path, one outstanding response
            axil_rsp.awready <= axil_req.awvalid && axil_req.wvalid &&
                                !axil_rsp.awready && !axil_rsp.bvalid;
            axil_rsp.wready  <= axil_req.awvalid && axil_req.wvalid &&
                                !axil_rsp.awready && !axil_rsp.bvalid;
            start <= 1'b0;
            if (wr_fire) begin
                axil_rsp.bvalid <= 1'b1;
                axil_rsp.bresp  <= wresp_next;
                if (!busy) begin
                    if (wr_w) begin
                        w_rows[waddr[3:2]] <= axil_req.wdata;
                    end
                    if (wr_a) begin
                        a_rows[waddr[3:2]] <= axil_req.wdata;
                    end
                    if (wr_ctrl) begin
                        start <= axil_req.wdata[0];
                    end
                end
            end else if (axil_rsp.bvalid && axil_req.bready) begin
                axil_rsp.bvalid <= 1'b0;
            end

            // read path
            axil_rsp.arready <= axil_req.arvalid && !axil_rsp.arready && !axil_rsp.rvalid;
            if (rd_fire) begin
                axil_rsp.rvalid <= 1'b1;
                axil_rsp.rdata  <= rdata_next;
                axil_rsp.rresp  <= rresp_next;
            end else if (axil_rsp.rvalid && axil_req.rready) begin
                axil_rsp.rvalid <= 1'b0;
            end

            // sticky done, cleared by the next run
            if (start) begin
                done_flag <= 1'b0;
            end else if (done) begin
                done_flag <= 1'b1;
            end

            if (result_we) begin
                c_rows[result_idx] <= result_row;
            end
        end
    end

endmodule

//--- logic/mmu_top.sv
// accelerator top: register block, controller, skew buffers and systolic array
`timescale 1ns/1ps

module mmu_top (
    input  logic               clk,
    input  logic               reset,
    input  mmu_pkg::axil_req_t axil_req,
    output mmu_pkg::axil_rsp_t axil_rsp
);

    mmu_pkg::data_vec_t w_rows [mmu_pkg::ARRAY_DIM];
    mmu_pkg::data_vec_t a_rows [mmu_pkg::ARRAY_DIM];
    logic               start;
    logic               busy;
    logic               done;
    logic               load_weight;
    logic               result_we;
    logic [1:0]         result_idx;
    mmu_pkg::data_vec_t weight_feed;
    mmu_pkg::data_vec_t data_feed;
    mmu_pkg::data_vec_t data_skewed;
    mmu_pkg::acc_vec_t  psum_east;
    mmu_pkg::acc_vec_t  row_aligned;
    mmu_pkg::acc_vec_t  result_data;

    axil_regs i_regs (
        .clk        (clk),
        .reset      (reset),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .w_rows     (w_rows),
        .a_rows     (a_rows),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .result_we  (result_we),
        .result_idx (result_idx),
        .result_row (result_data)
    );

    mmu_controller i_ctrl (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .w_rows     (w_rows),
        .a_rows     (a_rows),
        .load_weight(load_weight),
        .weight_feed(weight_feed),
        .data_feed  (data_feed),
        .result_row (row_aligned),
        .result_data(result_data),
        .result_we  (result_we),
        .result_idx (result_idx),
        .busy       (busy),
        .done       (done)
    );

    // column c enters c cycles late
    skew_buffer #(
        .elem_t (mmu_pkg::data_t),
        .reverse(1'b0)
    ) i_input_skew (
        .clk      (clk),
        .reset    (reset),
        .lanes_in (data_feed),
        .lanes_out(data_skewed)
    );

    systolic_array i_array (
        .clk        (clk),
        .reset      (reset),
        .load_weight(load_weight),
        .weight_feed(weight_feed),
        .data_feed  (data_skewed),
        .psum_east  (psum_east)
    );

    // row r sums leave r cycles late, hold them 3-r more
    skew_buffer #(
        .elem_t (mmu_pkg::acc_t),
        .reverse(1'b1)
    ) i_output_deskew (
        .clk      (clk),
        .reset    (reset),
        .lanes_in (psum_east),
        .lanes_out(row_aligned)
    );

endmodule

//--- dv/mmu_tb.sv
// testbench for mmu_top: clock, reset, AXI4-Lite bus tasks, checks, test sequence, timeout
`timescale 1ns/1ps

module mmu_tb;

    // W, A and C words of one case in the data file
    localparam int CASE_WORDS   = 24;
    localparam int BUSY_CASE    = 1;
    localparam int RESTART_CASE = 2;

    logic               clk;
    logic               reset;
    mmu_pkg::axil_req_t req;
    mmu_pkg::axil_rsp_t rsp;

    integer      seed        = 46;
    int          num_cases   = 0;
    int          cycles      = 0;
    int          cycle_limit = 500;
    logic [31:0] words [$];

    mmu_top i_dut (
        .clk     (clk),
        .reset   (reset),
        .axil_req(req),
        .axil_rsp(rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            abort_run($sformatf("Timeout: the run went past %0d clock cycles", cycle_limit));
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("Error at time %0t: %s is 0x%08h, expected 0x%08h",
                                $time, name, got, expected));
        end
    endtask

    ////////////////////
    // test data
    ////////////////////
    task automatic load_testdata();
        int          fd;
        string       line;
        logic [31:0] word;
        fd = $fopen("dv/mmu_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the test data file dv/mmu_testdata.txt");
        end
        // skip the column description
        line = "";
        while (line.len() == 0 || line[0] == "/" || line[0] == "\n") begin
            if ($fgets(line, fd) == 0) begin
                abort_run("the test data file holds no case count");
            end
        end
        if ($sscanf(line, "%d", num_cases) != 1 || num_cases < 1) begin
            abort_run("the case count in the test data file is not valid");
        end
        for (int k = 0; k < num_cases * CASE_WORDS; k++) begin
            if ($fscanf(fd, "%h", word) != 1) begin
                abort_run("the test data file ended before its last case");
            end
            words.push_back(word);
        end
        $fclose(fd);
        cycle_limit = num_cases * 300 + 500;
    endtask

    ////////////////////
    // bus tasks
    ////////////////////
    task automatic idle_gap();
        int gap;
        gap = {$random(seed)} % 4;
        repeat (gap) @(posedge clk);
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int delay;
        @(posedge clk);
        req.awvalid <= 1'b1;
        req.awaddr  <= addr;
        req.wvalid  <= 1'b1;
        req.wdata   <= data;
        req.wstrb   <= 4'hf;
        do @(negedge clk); while (!(rsp.awready && rsp.wready));
        @(posedge clk);
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        do @(negedge clk); while (!rsp.bvalid);
        resp  = rsp.bresp;
        // host back-pressure on the response
        delay = {$random(seed)} % 3;
        repeat (delay) @(posedge clk);
        @(posedge clk);
        req.bready <= 1'b1;
        @(posedge clk);
        req.bready <= 1'b0;
        idle_gap();
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int delay;
        @(posedge clk);
        req.arvalid <= 1'b1;
        req.araddr  <= addr;
        do @(negedge clk); while (!rsp.arready);
        @(posedge clk);
        req.arvalid <= 1'b0;
        do @(negedge clk); while (!rsp.rvalid);
        data  = rsp.rdata;
        resp  = rsp.rresp;
        delay = {$random(seed)} % 3;
        repeat (delay) @(posedge clk);
        @(posedge clk);
        req.rready <= 1'b1;
        @(posedge clk);
        req.rready <= 1'b0;
        idle_gap();
    endtask

    task automatic write_expect(input logic [7:0] addr, input logic [31:0] data,
                                input logic [1:0] exp_resp, input string name);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        check({name, " bresp"}, resp, exp_resp);
    endtask

    task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp_data,
                               input logic [1:0] exp_resp, input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, data, resp);
        check({name, " rresp"}, resp, exp_resp);
        check(name, data, exp_data);
    endtask

    ////////////////////
    // test steps
    ////////////////////
    task automatic load_operands(input int n);
        for (int r = 0; r < mmu_pkg::ARRAY_DIM; r++) begin
            write_expect(8'(mmu_pkg::ADDR_W_BASE + 4 * r), words[CASE_WORDS * n + r],
                         mmu_pkg::RESP_OKAY, $sformatf("W row %0d", r));
            write_expect(8'(mmu_pkg::ADDR_A_BASE + 4 * r), words[CASE_WORDS * n + 4 + r],
                         mmu_pkg::RESP_OKAY, $sformatf("A row %0d", r));
        end
    endtask

    task automatic read_results(input int n, input bit expect_zero);
        logic [31:0] expected;
        for (int i = 0; i < mmu_pkg::ARRAY_DIM; i++) begin
            for (int j = 0; j < mmu_pkg::ARRAY_DIM; j++) begin
                expected = expect_zero ? 32'h0 : words[CASE_WORDS * n + 8 + 4 * i + j];
                read_expect(8'(mmu_pkg::ADDR_C_BASE + 4 * (4 * i + j)), expected,
                            mmu_pkg::RESP_OKAY, $sformatf("C[%0d][%0d]", i, j));
            end
        end
    endtask

    // poll status until done with busy clear
    task automatic wait_done();
        logic [31:0] status;
        logic [1:0]  resp;
        status = '0;
        while (status !== 32'h2) begin
            axil_read(mmu_pkg::ADDR_STATUS, status, resp);
            check("STATUS rresp", resp, mmu_pkg::RESP_OKAY);
            if (status !== 32'h2) begin
                // a run in progress shows busy alone
                check("STATUS", status, 32'h1);
            end
        end
    endtask

    task automatic run_case(input int n);
        load_operands(n);
        write_expect(mmu_pkg::ADDR_CTRL, 32'h1, mmu_pkg::RESP_OKAY, "CTRL start");
        if (n == BUSY_CASE) begin
            // operands locked while the run is going
            write_expect(mmu_pkg::ADDR_W_BASE, ~words[CASE_WORDS * n],
                         mmu_pkg::RESP_SLVERR, "W row 0 while busy");
        end else if (n == RESTART_CASE) begin
            // second start lands inside the run and must not queue another one
            write_expect(mmu_pkg::ADDR_CTRL, 32'h1, mmu_pkg::RESP_OKAY, "CTRL start while busy");
        end else begin
            // busy set, done of the previous run cleared
            read_expect(mmu_pkg::ADDR_STATUS, 32'h1, mmu_pkg::RESP_OKAY, "STATUS after start");
        end
        wait_done();
        read_results(n, 1'b0);
        if (n == BUSY_CASE) begin
            read_expect(mmu_pkg::ADDR_W_BASE, words[CASE_WORDS * n], mmu_pkg::RESP_OKAY,
                        "W row 0 after run");
        end
    endtask

    initial begin
        req   = '0;
        reset = 1'b1;
        load_testdata();
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // state after reset
        read_expect(mmu_pkg::ADDR_STATUS, 32'h0, mmu_pkg::RESP_OKAY, "STATUS");
        read_results(0, 1'b1);

        // operand registers read back
        load_operands(0);
        for (int r = 0; r < mmu_pkg::ARRAY_DIM; r++) begin
            read_expect(8'(mmu_pkg::ADDR_W_BASE + 4 * r), words[r], mmu_pkg::RESP_OKAY,
                        $sformatf("W row %0d", r));
            read_expect(8'(mmu_pkg::ADDR_A_BASE + 4 * r), words[4 + r], mmu_pkg::RESP_OKAY,
                        $sformatf("A row %0d", r));
        end

        for (int n = 0; n < num_cases; n++) begin
            run_case(n);
        end

        // unmapped and read-only addresses
        write_expect(8'h30, 32'hffff_ffff, mmu_pkg::RESP_SLVERR, "write 0x30");
        write_expect(mmu_pkg::ADDR_STATUS, 32'h3, mmu_pkg::RESP_SLVERR, "write STATUS");
        read_expect(8'h30, 32'h0, mmu_pkg::RESP_SLVERR, "read 0x30");
        read_expect(mmu_pkg::ADDR_STATUS, 32'h2, mmu_pkg::RESP_OKAY, "STATUS at end");

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- files.f
logic/mmu_pkg.sv
logic/mac.sv
logic/systolic_array.sv
logic/skew_buffer.sv
logic/mmu_controller.sv
logic/axil_regs.sv
logic/mmu_top.sv
dv/mmu_tb.sv

//--- dv/mmu_testdata.txt
// hex words, int8 elements packed with byte c = column c; first value is the case count
// per case: W rows 0-3 then A rows 0-3, then expected C (int32) row-major on two lines
7
00000001 00000100 00010000 01000000 04030201 fcfdfeff 0500807f 281e140a
00000001 00000002 00000003 00000004 ffffffff fffffffe fffffffd fffffffc
0000007f ffffff80 00000000 00000005 0000000a 00000014 0000001e 00000028
00000000 00000000 00000000 00000000 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
80808080 80808080 80808080 80808080 80808080 80808080 80808080 80808080
00010000 00010000 00010000 00010000 00010000 00010000 00010000 00010000
00010000 00010000 00010000 00010000 00010000 00010000 00010000 00010000
80808080 80808080 80808080 80808080 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f
ffff0200 ffff0200 ffff0200 ffff0200 ffff0200 ffff0200 ffff0200 ffff0200
ffff0200 ffff0200 ffff0200 ffff0200 ffff0200 ffff0200 ffff0200 ffff0200
0705fd02 11f30bf8 e11de913 c0409c64 00000001 00000100 00010000 01000000
00000002 fffffffd 00000005 00000007 fffffff8 0000000b fffffff3 00000011
00000013 ffffffe9 0000001d ffffffe1 00000064 ffffff9c 00000040 ffffffc0
ff020001 03ff0100 01000102 0001fe01 ff000201 02010003 0102ff00 000101fe
00000000 00000004 ffffffff 00000005 00000007 fffffffd 00000008 fffffffe
00000005 ffffffff 00000002 ffffffff 00000000 00000002 fffffffb 00000006
01007f80 0001807f 00000000 05050505 0001807f 00000000 80808080 01010101
ffff8100 00007f01 ffffff80 0000007f 00000000 00000000 00000000 00000000
fffffe00 fffffe00 fffffd00 fffffd00 00000004 00000004 00000006 00000006
